// File: rtl/vga_pkg.sv
// shared types and constants for the VGA drawing pipeline
// every pipeline stage passes a vga_bus_t plus an rgb_t colour to the next
// modules import this package inside their body, ports use scoped names

`default_nettype none

package vga_pkg;

  // timing of one pixel as it moves down the pipeline
  typedef struct packed {
    logic [10:0] hcount;
    logic [10:0] vcount;
    logic        hsync;
    logic        vsync;
    logic        hblnk;
    logic        vblnk;
  } vga_bus_t;

  // 4 bits per channel, maps straight onto the r/g/b pins
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  // all zero, driven whenever either blanking is active
  localparam rgb_t BLACK = '{r: 4'h0, g: 4'h0, b: 4'h0};

  // one pixel frame around the active area
  localparam rgb_t BORDER_COLOR = '{r: 4'hf, g: 4'hf, b: 4'hf};

  // flat fill inside the border
  localparam rgb_t BG_COLOR = '{r: 4'h0, g: 4'h0, b: 4'h8};

  // solid rectangle moved by the buttons
  localparam rgb_t RECT_COLOR = '{r: 4'hf, g: 4'h8, b: 4'h0};

  // move decision taken once per frame by the rectangle controller
  typedef enum logic [1:0] {
    MOVE_NONE  = 2'd0,
    MOVE_LEFT  = 2'd1,
    MOVE_RIGHT = 2'd2
  } move_e;

endpackage

`default_nettype wire

// File: rtl/vga_timing.sv
// VGA raster timing generator
// free-running pixel and line counters with positive sync pulses and blanking
// output is one registered vga_bus_t per pclk cycle, first stage of the pipeline

`timescale 1ns/1ps
`default_nettype none

module vga_timing #(
  parameter int H_ACTIVE = 800,
  parameter int H_FP     = 40,
  parameter int H_SYNC   = 128,
  parameter int H_BP     = 88,
  parameter int V_ACTIVE = 600,
  parameter int V_FP     = 1,
  parameter int V_SYNC   = 4,
  parameter int V_BP     = 23
) (
  input  wire logic       pclk,
  input  wire logic       rst_n,
  output vga_pkg::vga_bus_t tim
);

  import vga_pkg::*;

  // totals and sync window edges, sized to the 11-bit counters
  localparam logic [10:0] H_TOTAL   = 11'(H_ACTIVE + H_FP + H_SYNC + H_BP);
  localparam logic [10:0] V_TOTAL   = 11'(V_ACTIVE + V_FP + V_SYNC + V_BP);
  localparam logic [10:0] H_ACT_END = 11'(H_ACTIVE);
  localparam logic [10:0] V_ACT_END = 11'(V_ACTIVE);
  localparam logic [10:0] HS_START  = 11'(H_ACTIVE + H_FP);
  localparam logic [10:0] HS_END    = 11'(H_ACTIVE + H_FP + H_SYNC);
  localparam logic [10:0] VS_START  = 11'(V_ACTIVE + V_FP);
  localparam logic [10:0] VS_END    = 11'(V_ACTIVE + V_FP + V_SYNC);

  vga_bus_t tim_nxt;
  logic     h_wrap;

  always_comb begin
    tim_nxt = tim;
    h_wrap  = (tim.hcount == H_TOTAL - 11'd1);

    // horizontal counter wraps at the line total
    if (h_wrap) begin
      tim_nxt.hcount = '0;
    end else begin
      tim_nxt.hcount = tim.hcount + 11'd1;
    end

    // vertical counter steps once per line, on the horizontal wrap
    if (h_wrap) begin
      if (tim.vcount == V_TOTAL - 11'd1) begin
        tim_nxt.vcount = '0;
      end else begin
        tim_nxt.vcount = tim.vcount + 11'd1;
      end
    end

    // decode from the next counts so every field registers in the same cycle
    tim_nxt.hsync = (tim_nxt.hcount >= HS_START) && (tim_nxt.hcount < HS_END);
    tim_nxt.vsync = (tim_nxt.vcount >= VS_START) && (tim_nxt.vcount < VS_END);
    tim_nxt.hblnk = (tim_nxt.hcount >= H_ACT_END);
    tim_nxt.vblnk = (tim_nxt.vcount >= V_ACT_END);
  end

  // reset parks the raster at pixel 0 of line 0, sync and blanking low
  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      tim <= '0;
    end else begin
      tim <= tim_nxt;
    end
  end

  // counter must never run past the line total, or sync would be lost
  a_hcount_range : assert property (
    @(posedge pclk) disable iff (!rst_n)
    (tim.hcount < H_TOTAL) && (tim.vcount < V_TOTAL)
  );

endmodule

`default_nettype wire

// File: rtl/draw_background.sv
// background stage of the drawing pipeline
// delays the timing bundle by one cycle and adds a colour for each pixel
// white border on the outer active pixels, dark blue fill, black while blanked

`timescale 1ns/1ps
`default_nettype none

module draw_background #(
  parameter int H_ACTIVE = 800,
  parameter int V_ACTIVE = 600
) (
  input  wire logic              pclk,
  input  wire logic              rst_n,
  input  wire vga_pkg::vga_bus_t bus_in,
  output vga_pkg::vga_bus_t      bus_out,
  output vga_pkg::rgb_t          rgb_out
);

  import vga_pkg::*;

  // last active column and row carry the border
  localparam logic [10:0] H_LAST = 11'(H_ACTIVE - 1);
  localparam logic [10:0] V_LAST = 11'(V_ACTIVE - 1);

  rgb_t rgb_nxt;
  logic on_border;

  always_comb begin
    on_border = (bus_in.hcount == '0) || (bus_in.hcount == H_LAST) ||
                (bus_in.vcount == '0) || (bus_in.vcount == V_LAST);

    // blanking wins over everything, then border, then fill
    if (bus_in.hblnk || bus_in.vblnk) begin
      rgb_nxt = BLACK;
    end else if (on_border) begin
      rgb_nxt = BORDER_COLOR;
    end else begin
      rgb_nxt = BG_COLOR;
    end
  end

  // bundle travels unchanged, colour is aligned to it
  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      bus_out <= '0;
      rgb_out <= BLACK;
    end else begin
      bus_out <= bus_in;
      rgb_out <= rgb_nxt;
    end
  end

endmodule

`default_nettype wire

// File: rtl/position_rect_ctl.sv
// horizontal position controller for the rectangle
// left/right buttons pass a two-flop synchroniser, then move the position
// by STEP pixels once per frame, clamped so the rectangle stays on screen

`timescale 1ns/1ps
`default_nettype none

module position_rect_ctl #(
  parameter int H_ACTIVE = 800,
  parameter int RECT_W   = 64,
  parameter int STEP     = 4
) (
  input  wire logic              pclk,
  input  wire logic              rst_n,
  input  wire logic              left,
  input  wire logic              right,
  input  wire vga_pkg::vga_bus_t tim,
  output logic [10:0]            xpos
);

  import vga_pkg::*;

  // rightmost legal left edge and the centred start position
  localparam logic [10:0] X_MAX  = 11'(H_ACTIVE - RECT_W);
  localparam logic [10:0] X_INIT = 11'((H_ACTIVE - RECT_W) / 2);
  localparam logic [10:0] STEP_W = 11'(STEP);

  logic [1:0]  left_sync;
  logic [1:0]  right_sync;
  logic        frame_start;
  move_e       move;
  logic [10:0] xpos_nxt;

  // buttons are asynchronous to pclk
  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      left_sync  <= '0;
      right_sync <= '0;
    end else begin
      left_sync  <= {left_sync[0], left};
      right_sync <= {right_sync[0], right};
    end
  end

  // first pixel of the frame, before any rectangle row is drawn
  assign frame_start = (tim.hcount == '0) && (tim.vcount == '0);

  always_comb begin
    // both held cancels out
    case ({left_sync[1], right_sync[1]})
      2'b10:   move = MOVE_LEFT;
      2'b01:   move = MOVE_RIGHT;
      default: move = MOVE_NONE;
    endcase

    // saturating step, differences stay non-negative since xpos <= X_MAX
    case (move)
      MOVE_LEFT:  xpos_nxt = (xpos < STEP_W) ? '0 : xpos - STEP_W;
      MOVE_RIGHT: xpos_nxt = (X_MAX - xpos < STEP_W) ? X_MAX : xpos + STEP_W;
      default:    xpos_nxt = xpos;
    endcase
  end

  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      xpos <= X_INIT;
    end else if (frame_start) begin
      xpos <= xpos_nxt;
    end
  end

  // rectangle must never extend past the last active column
  a_xpos_clamp : assert property (
    @(posedge pclk) disable iff (!rst_n)
    xpos <= X_MAX
  );

endmodule

`default_nettype wire

// File: rtl/draw_rect.sv
// rectangle overlay stage of the drawing pipeline
// delays the bundle by one cycle like the background stage
// pixels inside the rectangle get RECT_COLOR, all others keep the incoming colour
// left edge comes from the controller, size and row are fixed by parameters

`timescale 1ns/1ps
`default_nettype none

module draw_rect #(
  parameter int RECT_W = 64,
  parameter int RECT_H = 32,
  parameter int RECT_Y = 500
) (
  input  wire logic              pclk,
  input  wire logic              rst_n,
  input  wire logic [10:0]       xpos,
  input  wire vga_pkg::vga_bus_t bus_in,
  input  wire vga_pkg::rgb_t     rgb_in,
  output vga_pkg::vga_bus_t      bus_out,
  output vga_pkg::rgb_t          rgb_out
);

  import vga_pkg::*;

  localparam logic [11:0] RECT_W_W = 12'(RECT_W);
  localparam logic [10:0] Y_TOP    = 11'(RECT_Y);
  localparam logic [10:0] Y_END    = 11'(RECT_Y + RECT_H);

  // one bit wider so xpos + RECT_W cannot wrap near the right edge
  logic [11:0] x_end;
  logic        in_cols;
  logic        in_rows;
  logic        in_rect;
  rgb_t        rgb_nxt;

  always_comb begin
    x_end   = {1'b0, xpos} + RECT_W_W;
    in_cols = (bus_in.hcount >= xpos) && ({1'b0, bus_in.hcount} < x_end);
    in_rows = (bus_in.vcount >= Y_TOP) && (bus_in.vcount < Y_END);

    // never paint over blanking, the incoming colour is black there
    in_rect = in_cols && in_rows && !bus_in.hblnk && !bus_in.vblnk;

    if (in_rect) begin
      rgb_nxt = RECT_COLOR;
    end else begin
      rgb_nxt = rgb_in;
    end
  end

  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      bus_out <= '0;
      rgb_out <= BLACK;
    end else begin
      bus_out <= bus_in;
      rgb_out <= rgb_nxt;
    end
  end

  // colour must be black on the pins during blanking
  // relies on the background stage blanking its colour one cycle earlier
  a_blank_black : assert property (
    @(posedge pclk) disable iff (!rst_n)
    (bus_out.hblnk || bus_out.vblnk) |-> (rgb_out == BLACK)
  );

endmodule

`default_nettype wire

// File: rtl/vga_top.sv
// top level of the VGA display pipeline
// timing -> background -> rectangle, with the button controller feeding xpos
// defaults are 800x600 timing, override parameters for smaller frames

`timescale 1ns/1ps
`default_nettype none

module vga_top #(
  parameter int H_ACTIVE = 800,
  parameter int H_FP     = 40,
  parameter int H_SYNC   = 128,
  parameter int H_BP     = 88,
  parameter int V_ACTIVE = 600,
  parameter int V_FP     = 1,
  parameter int V_SYNC   = 4,
  parameter int V_BP     = 23,
  parameter int RECT_W   = 64,
  parameter int RECT_H   = 32,
  parameter int RECT_Y   = 500,
  parameter int STEP     = 4
) (
  input  wire logic pclk,
  input  wire logic rst_n,
  input  wire logic left,
  input  wire logic right,
  output logic       hs,
  output logic       vs,
  output logic [3:0] r,
  output logic [3:0] g,
  output logic [3:0] b
);

  import vga_pkg::*;

  vga_bus_t    tim;
  vga_bus_t    bg_bus;
  rgb_t        bg_rgb;
  vga_bus_t    rect_bus;
  rgb_t        rect_rgb;
  logic [10:0] xpos;

  // counters, first pipeline stage
  vga_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
    .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
  ) i_timing (
    .pclk (pclk),
    .rst_n(rst_n),
    .tim  (tim)
  );

  draw_background #(
    .H_ACTIVE(H_ACTIVE),
    .V_ACTIVE(V_ACTIVE)
  ) i_background (
    .pclk   (pclk),
    .rst_n  (rst_n),
    .bus_in (tim),
    .bus_out(bg_bus),
    .rgb_out(bg_rgb)
  );

  // watches the counter stage for frame start
  position_rect_ctl #(
    .H_ACTIVE(H_ACTIVE),
    .RECT_W  (RECT_W),
    .STEP    (STEP)
  ) i_rect_ctl (
    .pclk (pclk),
    .rst_n(rst_n),
    .left (left),
    .right(right),
    .tim  (tim),
    .xpos (xpos)
  );

  draw_rect #(
    .RECT_W(RECT_W),
    .RECT_H(RECT_H),
    .RECT_Y(RECT_Y)
  ) i_rect (
    .pclk   (pclk),
    .rst_n  (rst_n),
    .xpos   (xpos),
    .bus_in (bg_bus),
    .rgb_in (bg_rgb),
    .bus_out(rect_bus),
    .rgb_out(rect_rgb)
  );

  // sync and colour leave the last stage together, two cycles after the counters
  assign hs = rect_bus.hsync;
  assign vs = rect_bus.vsync;
  assign r  = rect_rgb.r;
  assign g  = rect_rgb.g;
  assign b  = rect_rgb.b;

endmodule

`default_nettype wire

// File: sim/vga_top_tb.sv
// directed testbench for the VGA display pipeline
// runs a tiny 88x58 frame and checks sync, blanking, background and rectangle
// all results are sampled on the top-level pins at the falling clock edge

`timescale 1ns/1ps
`default_nettype none

module vga_top_tb;

  import vga_pkg::*;

  // small raster so a whole frame takes a few thousand cycles
  localparam int H_ACTIVE = 64;
  localparam int H_FP     = 4;
  localparam int H_SYNC   = 8;
  localparam int H_BP     = 12;
  localparam int V_ACTIVE = 48;
  localparam int V_FP     = 2;
  localparam int V_SYNC   = 3;
  localparam int V_BP     = 5;
  localparam int RECT_W   = 16;
  localparam int RECT_H   = 8;
  localparam int RECT_Y   = 20;
  localparam int STEP     = 4;

  localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;
  localparam int X_MAX   = H_ACTIVE - RECT_W;
  // longest legal wait is a bit under one frame
  localparam int TIMEOUT = 2 * H_TOTAL * V_TOTAL;
  // buttons change here, well away from the frame start
  localparam int MID_ROW = V_ACTIVE / 2;

  logic       pclk;
  logic       rst_n;
  logic       left;
  logic       right;
  logic       hs;
  logic       vs;
  logic [3:0] r;
  logic [3:0] g;
  logic [3:0] b;

  // left edge the rectangle should show right now
  int exp_x;

  vga_top #(
    .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
    .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
    .RECT_W(RECT_W), .RECT_H(RECT_H), .RECT_Y(RECT_Y), .STEP(STEP)
  ) i_dut (
    .pclk (pclk),
    .rst_n(rst_n),
    .left (left),
    .right(right),
    .hs   (hs),
    .vs   (vs),
    .r    (r),
    .g    (g),
    .b    (b)
  );

  // 40 ns period
  always #20 pclk = ~pclk;

  task automatic abort_run(input string what);
    $display("error at %0t ns: %s", $time, what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // counts falling edges until hs or vs changes to the wanted level
  task automatic wait_edge(input bit use_vs, input bit rising, input string what,
                           output int cycles);
    logic prev;
    logic cur;
    bit   done;
    int   n;
    prev = use_vs ? vs : hs;
    done = 1'b0;
    n    = 0;
    while (!done && n < TIMEOUT) begin
      @(negedge pclk);
      n++;
      cur  = use_vs ? vs : hs;
      done = (cur == rising) && (prev != rising);
      prev = cur;
    end
    cycles = n;
    if (!done) begin
      abort_run({"the ", what, " edge never came"});
    end
  endtask

  // stops on the hs fall right before the given active row
  task automatic goto_row(input int row);
    int n;
    wait_edge(1'b1, 1'b0, "vs falling", n);
    repeat (V_BP + row) begin
      wait_edge(1'b0, 1'b0, "hs falling", n);
    end
  endtask

  // background colour per pixel, x counts from the first active column
  function automatic logic [11:0] bg_expected(input int x, input int row);
    if (x < 0 || x >= H_ACTIVE) begin
      return 12'h000;
    end
    if (x == 0 || x == H_ACTIVE - 1 || row == 0 || row == V_ACTIVE - 1) begin
      return BORDER_COLOR;
    end
    return BG_COLOR;
  endfunction

  // scans one line after goto_row, column x arrives H_BP + x cycles after the hs fall
  task automatic scan_rect(output int first, output int count);
    int x;
    first = -1;
    count = 0;
    for (int k = 1; k < H_BP + H_ACTIVE + H_FP; k++) begin
      @(negedge pclk);
      x = k - H_BP;
      if ({r, g, b} == RECT_COLOR) begin
        if (count == 0) begin
          first = x;
        end
        count++;
      end
    end
  endtask

  // holds reset for 10 cycles with quiet outputs, then releases it
  task automatic test_reset_outputs();
    for (int i = 0; i < 10; i++) begin
      @(negedge pclk);
      check_eq(32'(hs), 32'd0, "hs during reset");
      check_eq(32'(vs), 32'd0, "vs during reset");
      check_eq(32'({r, g, b}), 32'd0, "colour during reset");
    end
    rst_n = 1'b1;
  endtask

  task automatic test_sync_timing();
    int n_high;
    int n_low;
    wait_edge(1'b0, 1'b1, "hs rising", n_low);
    wait_edge(1'b0, 1'b0, "hs falling", n_high);
    wait_edge(1'b0, 1'b1, "hs rising", n_low);
    check_eq(n_high, H_SYNC, "hs high time");
    check_eq(n_high + n_low, H_TOTAL, "hs period");
    wait_edge(1'b1, 1'b1, "vs rising", n_low);
    wait_edge(1'b1, 1'b0, "vs falling", n_high);
    wait_edge(1'b1, 1'b1, "vs rising", n_low);
    check_eq(n_high, V_SYNC * H_TOTAL, "vs high time");
    check_eq(n_high + n_low, H_TOTAL * V_TOTAL, "vs period");
  endtask

  // back porch, whole active part and front porch of row 5
  task automatic test_background();
    int x;
    goto_row(5);
    for (int k = 1; k < H_BP + H_ACTIVE + H_FP; k++) begin
      @(negedge pclk);
      x = k - H_BP;
      check_eq(32'({r, g, b}), 32'(bg_expected(x, 5)), $sformatf("row 5 column %0d", x));
    end
  endtask

  task automatic test_rect_reset();
    int first;
    int count;
    exp_x = (H_ACTIVE - RECT_W) / 2;
    goto_row(RECT_Y);
    scan_rect(first, count);
    check_eq(first, exp_x, "rectangle left edge after reset");
    check_eq(count, RECT_W, "rectangle width after reset");
    // first row below the rectangle
    goto_row(RECT_Y + RECT_H);
    scan_rect(first, count);
    check_eq(count, 0, "rectangle pixels below its last row");
  endtask

  // holds the buttons across a number of frame starts, then measures the edge
  task automatic test_move(input logic hold_left, input logic hold_right, input int frames);
    int n;
    int first;
    int count;
    if (hold_right && !hold_left) begin
      exp_x = (exp_x + STEP * frames > X_MAX) ? X_MAX : exp_x + STEP * frames;
    end else if (hold_left && !hold_right) begin
      exp_x = (exp_x < STEP * frames) ? 0 : exp_x - STEP * frames;
    end
    goto_row(MID_ROW);
    left  = hold_left;
    right = hold_right;
    // one frame start follows every vs fall
    repeat (frames) begin
      wait_edge(1'b1, 1'b0, "vs falling", n);
    end
    repeat (V_BP + MID_ROW) begin
      wait_edge(1'b0, 1'b0, "hs falling", n);
    end
    left  = 1'b0;
    right = 1'b0;
    goto_row(RECT_Y);
    scan_rect(first, count);
    check_eq(first, exp_x, $sformatf("left edge after %0d frames of l=%0b r=%0b",
                                     frames, hold_left, hold_right));
    check_eq(count, RECT_W, "rectangle width after a move");
  endtask

  initial begin
    pclk  = 1'b0;
    rst_n = 1'b0;
    left  = 1'b0;
    right = 1'b0;
    exp_x = 0;
    test_reset_outputs();
    test_sync_timing();
    test_background();
    test_rect_reset();
    test_move(1'b0, 1'b1, 2);
    // long enough to hit the right clamp
    test_move(1'b0, 1'b1, 20);
    test_move(1'b1, 1'b0, 20);
    // off the left clamp so a step either way would show
    test_move(1'b0, 1'b1, 2);
    test_move(1'b1, 1'b1, 2);
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: vga_top.f
rtl/vga_pkg.sv
rtl/vga_timing.sv
rtl/draw_background.sv
rtl/position_rect_ctl.sv
rtl/draw_rect.sv
rtl/vga_top.sv
sim/vga_top_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := vga_top_tb
FILELIST  := vga_top.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# the log decides the result, not the simulator exit code
run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "Simulation passed" $(LOG); then \
		echo "run result: PASS"; \
	else \
		echo "run result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
